//--- z80_op_pkg.sv
// Opcode fields, register codes and T-state numbers for the ED-prefixed IN/OUT execution.
// Imported by the sequencer, the decoder and the register file.
package z80_op_pkg;

    typedef logic [2:0] reg_code_t;
    typedef logic [4:0] tstate_t;

    localparam reg_code_t REG_B    = 3'b000;
    localparam reg_code_t REG_C    = 3'b001;
    localparam reg_code_t REG_D    = 3'b010;
    localparam reg_code_t REG_E    = 3'b011;
    localparam reg_code_t REG_H    = 3'b100;
    localparam reg_code_t REG_L    = 3'b101;
    localparam reg_code_t REG_HL_M = 3'b110; // (HL) slot, F or 0 for these opcodes.
    localparam reg_code_t REG_A    = 3'b111;

    localparam int NUM_REGS = 7;

    localparam tstate_t T_FIRST = 5'd4;
    localparam tstate_t T_LAST  = 5'd7;

    localparam int OP_IN_BIT = 0; // 0 is IN, 1 is OUT.
    localparam int RRR_LSB   = 3;

    // one bit per register, B at bit 0 up to A at bit 6.
    function automatic logic [NUM_REGS-1:0] reg_onehot(reg_code_t code);
        logic [NUM_REGS-1:0] hot;
        hot = '0;
        case (code)
            REG_B:   hot[0] = 1'b1;
            REG_C:   hot[1] = 1'b1;
            REG_D:   hot[2] = 1'b1;
            REG_E:   hot[3] = 1'b1;
            REG_H:   hot[4] = 1'b1;
            REG_L:   hot[5] = 1'b1;
            REG_A:   hot[6] = 1'b1;
            default: hot = '0;
        endcase
        return hot;
    endfunction

endpackage

//--- z80_bus_pkg.sv
// Data bus, port address and flag register definitions.
// Imported wherever bytes, port addresses or flag bits are handled.
package z80_bus_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] port_addr_t; // {B,C}.
    typedef logic [7:0]        flags_t;

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_H  = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

endpackage

//--- io_sequencer.sv
// Latches the IN/OUT opcode and steps T4 to T7, holding T5 for the I/O wait states.
`timescale 1ns/100ps

module io_sequencer #(
    parameter int WAIT_CYCLES = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  z80_bus_pkg::data_t  opcode,
    input  z80_bus_pkg::data_t  io_rdata,
    output z80_op_pkg::tstate_t xpt,
    output z80_bus_pkg::data_t  op_latched,
    output z80_bus_pkg::data_t  in_data,
    output logic                busy,
    output logic                done
);
    import z80_op_pkg::*;

    localparam int WW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
    localparam logic [WW-1:0] WAIT_LAST = WW'(WAIT_CYCLES);
    localparam tstate_t T_WAIT = T_FIRST + 5'd1; // port cycle, stretched.
    localparam tstate_t T_READ = T_LAST - 5'd1;

    logic [WW-1:0] wait_cnt;
    logic          wait_over;

    assign busy      = (xpt != '0);
    assign done      = (xpt == T_LAST);
    assign wait_over = (wait_cnt == WAIT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xpt      <= '0;
            wait_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                xpt <= T_FIRST;
            end
        end else if (done) begin
            xpt <= '0; // back to idle.
        end else if (xpt == T_WAIT && !wait_over) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            xpt      <= xpt + 5'd1;
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op_latched <= opcode;
        end
        if (xpt == T_READ) begin
            in_data <= io_rdata; // sampled at the end of T6.
        end
    end

endmodule

//--- io_op_decoder.sv
// Turns the T-state and the latched IN r,(C) / OUT (C),r opcode into
// register select, port cycle, register write and flag strobes.
`timescale 1ns/100ps

module io_op_decoder (
    input  z80_op_pkg::tstate_t                xpt,
    input  z80_bus_pkg::data_t                 source,
    output logic                               select_addr_bc,
    output logic [z80_op_pkg::NUM_REGS-1:0]    select_dt,
    output logic                               port_in,
    output logic                               port_out,
    output logic [z80_op_pkg::NUM_REGS-1:0]    reg_write,
    output logic                               flag_write
);
    import z80_op_pkg::*;

    logic                t4_7;
    logic [T_LAST:T_FIRST] decoded_xpt;
    logic                is_out;
    logic                port_cycle;
    reg_code_t           rrr;
    logic [NUM_REGS-1:0] sel_hot;
    logic [NUM_REGS-1:0] wr_hot;

    // T-state one-hot, enabled only inside T4..T7.
    assign t4_7 = (xpt >= T_FIRST) && (xpt <= T_LAST);

    always_comb begin
        decoded_xpt = '0;
        for (int t = T_FIRST; t <= T_LAST; t++) begin
            decoded_xpt[t] = t4_7 && (xpt[1:0] == t[1:0]);
        end
    end

    assign is_out = source[OP_IN_BIT];
    assign rrr    = source[RRR_LSB +: 3];

    // code 110 reads as A and writes as H.
    assign sel_hot = (rrr == REG_HL_M) ? reg_onehot(REG_A) : reg_onehot(rrr);
    assign wr_hot  = (rrr == REG_HL_M) ? reg_onehot(REG_H) : reg_onehot(rrr);

    assign port_cycle = decoded_xpt[T_FIRST + 5'd1] | decoded_xpt[T_LAST - 5'd1];

    assign select_addr_bc = t4_7;
    assign select_dt      = (t4_7 && is_out) ? sel_hot : '0; // OUT data source.

    assign port_in  = port_cycle & ~is_out;
    assign port_out = port_cycle & is_out;

    // IN writes back in T7.
    assign reg_write  = (decoded_xpt[T_LAST] && !is_out) ? wr_hot : '0;
    assign flag_write = decoded_xpt[T_LAST] & ~is_out;

endmodule

//--- z80_reg_file.sv
// B, C, D, E, H, L and A with a setup load port, decoder write strobes,
// a one-hot read select and the {B,C} port address.
`timescale 1ns/100ps

module z80_reg_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  z80_op_pkg::reg_code_t              load_sel,
    input  z80_bus_pkg::data_t                 load_data,
    input  logic [z80_op_pkg::NUM_REGS-1:0]    reg_write,
    input  z80_bus_pkg::data_t                 write_data,
    input  logic [z80_op_pkg::NUM_REGS-1:0]    select_dt,
    output z80_bus_pkg::data_t                 out_data,
    output z80_bus_pkg::port_addr_t            port_addr
);
    import z80_op_pkg::*;
    import z80_bus_pkg::*;

    data_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] load_hot;

    assign load_hot = load ? reg_onehot(load_sel) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (reg_write[i]) begin
                    regs[i] <= write_data; // decoder write wins.
                end else if (load_hot[i]) begin
                    regs[i] <= load_data;
                end
            end
        end
    end

    always_comb begin
        out_data = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (select_dt[i]) begin
                out_data = out_data | regs[i];
            end
        end
    end

    assign port_addr = {regs[0], regs[1]}; // B high, C low.

endmodule

//--- io_flag_unit.sv
// F register. IN r,(C) sets S, Z and P/V from the byte read and clears H and N.
`timescale 1ns/100ps

module io_flag_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flag_write,
    input  z80_bus_pkg::data_t  in_data,
    output z80_bus_pkg::flags_t flags
);
    import z80_bus_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_write) begin
            flags[FLAG_S]  <= in_data[DATA_W-1];
            flags[FLAG_Z]  <= (in_data == '0);
            flags[FLAG_PV] <= ~^in_data; // even parity.
            flags[FLAG_H]  <= 1'b0;
            flags[FLAG_N]  <= 1'b0;
            // C and bits 5, 3 hold.
        end
    end

endmodule

//--- io_exec_top.sv
// Top of the IN r,(C) / OUT (C),r execution unit, T4 to T7 after the fetch.
`timescale 1ns/100ps

module io_exec_top #(
    parameter int WAIT_CYCLES = 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  z80_bus_pkg::data_t      opcode,
    output logic                    busy,
    output logic                    done,
    input  logic                    load,
    input  z80_op_pkg::reg_code_t   load_sel,
    input  z80_bus_pkg::data_t      load_data,
    output z80_bus_pkg::port_addr_t io_addr,
    output logic                    io_rd,
    output logic                    io_wr,
    output z80_bus_pkg::data_t      io_wdata,
    input  z80_bus_pkg::data_t      io_rdata,
    output z80_bus_pkg::flags_t     flags
);
    import z80_op_pkg::*;
    import z80_bus_pkg::*;

    tstate_t             xpt;
    data_t               op_latched;
    data_t               in_data;
    data_t               out_data;
    port_addr_t          port_addr;
    logic                select_addr_bc;
    logic [NUM_REGS-1:0] select_dt;
    logic [NUM_REGS-1:0] reg_write;
    logic                flag_write;

    io_sequencer #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .opcode    (opcode),
        .io_rdata  (io_rdata),
        .xpt       (xpt),
        .op_latched(op_latched),
        .in_data   (in_data),
        .busy      (busy),
        .done      (done)
    );

    io_op_decoder u_dec (
        .xpt           (xpt),
        .source        (op_latched),
        .select_addr_bc(select_addr_bc),
        .select_dt     (select_dt),
        .port_in       (io_rd),
        .port_out      (io_wr),
        .reg_write     (reg_write),
        .flag_write    (flag_write)
    );

    z80_reg_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load && !busy), // setup only.
        .load_sel  (load_sel),
        .load_data (load_data),
        .reg_write (reg_write),
        .write_data(in_data),
        .select_dt (select_dt),
        .out_data  (out_data),
        .port_addr (port_addr)
    );

    io_flag_unit u_flags (
        .clk       (clk),
        .rst_n     (rst_n),
        .flag_write(flag_write),
        .in_data   (in_data),
        .flags     (flags)
    );

    assign io_addr  = select_addr_bc ? port_addr : '0;
    assign io_wdata = out_data;

endmodule

//--- io_exec_assert.sv
// Strobe timing rules for the IN/OUT execution unit, bound into io_exec_top.
`timescale 1ns/100ps

module io_exec_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic io_rd,
    input logic io_wr
);

    int unsigned fail_count = 0;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(io_rd && io_wr))
        else begin
            fail_count++;
            $error("io_rd and io_wr high in the same cycle");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $error("done held for more than one cycle");
        end

    strobe_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                     (io_rd || io_wr) |-> busy)
        else begin
            fail_count++;
            $error("port strobe outside busy");
        end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !(io_rd || io_wr || done))
        else begin
            fail_count++;
            $error("strobe high during reset");
        end

endmodule

bind io_exec_top io_exec_assert u_assert (
    .clk  (clk),
    .rst_n(rst_n),
    .busy (busy),
    .done (done),
    .io_rd(io_rd),
    .io_wr(io_wr)
);

//--- tb_io_exec.sv
// Testbench for the IN r,(C) / OUT (C),r execution unit.
// Applies a table of cases against a port model and reads registers back with OUT.
`timescale 1ns/100ps

module tb_io_exec;
    import z80_op_pkg::*;
    import z80_bus_pkg::*;

    localparam int WAIT_CYCLES = 2;
    localparam int TIMEOUT     = 50; // cycles.

    typedef struct {
        data_t  opcode;
        data_t  b;
        data_t  c;
        data_t  pre;
        data_t  port_byte;
        data_t  exp_reg;
        flags_t exp_flags;
        logic   poke; // second start while busy.
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       start;
    data_t      opcode;
    logic       busy;
    logic       done;
    logic       load;
    reg_code_t  load_sel;
    data_t      load_data;
    port_addr_t io_addr;
    logic       io_rd;
    logic       io_wr;
    data_t      io_wdata;
    data_t      io_rdata;
    flags_t     flags;

    entry_t     table_q[$];
    data_t      model [8];
    data_t      port_byte = 8'h00;
    int         rd_windows = 0;
    int         wr_windows = 0;
    logic       rd_q = 1'b0;
    logic       wr_q = 1'b0;
    port_addr_t rd_addr;
    port_addr_t wr_addr;
    data_t      wr_data;
    int         error_count = 0;

    io_exec_top #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .opcode   (opcode),
        .busy     (busy),
        .done     (done),
        .load     (load),
        .load_sel (load_sel),
        .load_data(load_data),
        .io_addr  (io_addr),
        .io_rd    (io_rd),
        .io_wr    (io_wr),
        .io_wdata (io_wdata),
        .io_rdata (io_rdata),
        .flags    (flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // port model and window recorder.
    always @(posedge clk) begin
        io_rdata <= io_rd ? port_byte : 8'h00;
        rd_q     <= io_rd;
        wr_q     <= io_wr;
        if (io_rd && !rd_q) begin
            rd_windows <= rd_windows + 1;
        end
        if (io_wr && !wr_q) begin
            wr_windows <= wr_windows + 1;
        end
        if (io_rd) begin
            rd_addr <= io_addr;
        end
        if (io_wr) begin
            wr_addr <= io_addr;
            wr_data <= io_wdata;
        end
    end

    // failures of the bound strobe checker.
    always @(negedge clk) begin
        if (u_dut.u_assert.fail_count != 0) begin
            $display("an assertion on the strobe timing failed");
            fail_and_stop();
        end
    end

    task automatic fail_and_stop();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("FAILED at %0t: %s", $time, msg);
        fail_and_stop();
    endtask

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %02h, expected %02h", what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input port_addr_t got, input port_addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %04h, expected %04h", what, got, exp));
        end
    endtask

    task automatic check_flags(input string what, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %08b, expected %08b", what, got, exp));
        end
    endtask

    task automatic add_entry(input data_t op, input data_t b, input data_t c, input data_t pre,
                             input data_t port, input data_t exp_reg, input flags_t exp_flags,
                             input logic poke);
        entry_t e;
        e = '{op, b, c, pre, port, exp_reg, exp_flags, poke};
        table_q.push_back(e);
    endtask

    task automatic run_op(input data_t op, input logic poke);
        int n;
        int exp_n;
        rd_windows = 0;
        wr_windows = 0;
        exp_n = 4 + WAIT_CYCLES - (poke ? 2 : 0);
        @(posedge clk);
        start  <= 1'b1;
        opcode <= op;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin
            @(posedge clk);
            start  <= 1'b1; // lands in T5, must be ignored.
            opcode <= 8'h41;
            @(posedge clk);
            start <= 1'b0;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: done did not rise within %0d cycles of start", TIMEOUT);
                fail_and_stop();
            end
            if (busy !== 1'b1) begin
                report_error("busy low while the instruction runs");
            end
        end while (!done);
        if (n != exp_n) begin
            report_error($sformatf("done after %0d cycles, expected %0d", n, exp_n));
        end
        @(posedge clk);
        if (busy !== 1'b0) begin
            report_error("busy still high one cycle after done");
        end
    endtask

    task automatic preload_all();
        for (int i = 0; i < 8; i++) begin
            if (i != REG_HL_M) begin
                @(posedge clk);
                load      <= 1'b1;
                load_sel  <= reg_code_t'(i);
                load_data <= model[i];
            end
        end
        @(posedge clk);
        load <= 1'b0;
    endtask

    task automatic readback_all();
        for (int i = 0; i < 8; i++) begin
            if (i != REG_HL_M) begin
                run_op({2'b01, reg_code_t'(i), 3'b001}, 1'b0);
                if (wr_windows != 1) begin
                    report_error($sformatf("readback gave %0d write windows", wr_windows));
                end
                check_data($sformatf("register code %0d", i), wr_data, model[i]);
            end
        end
    endtask

    initial begin
        entry_t     e;
        reg_code_t  code;
        port_addr_t exp_addr;
        void'($urandom(32'h09075fd2));
        rst_n     = 1'b0;
        start     = 1'b0;
        opcode    = 8'h00;
        load      = 1'b0;
        load_sel  = REG_B;
        load_data = 8'h00;
        io_rdata  = 8'h00;
        for (int i = 0; i < 8; i++) begin
            model[i] = 8'h00;
        end

        //        opcode B      C      pre    port   reg    flags  poke
        add_entry(8'h41, 8'h12, 8'h34, 8'h9a, 8'h00, 8'h9a, 8'h00, 1'b0);
        add_entry(8'h49, 8'h56, 8'h78, 8'h3c, 8'h00, 8'h3c, 8'h00, 1'b0);
        add_entry(8'h51, 8'ha0, 8'hfe, 8'h5a, 8'h00, 8'h5a, 8'h00, 1'b0);
        add_entry(8'h59, 8'h01, 8'h23, 8'hc3, 8'h00, 8'hc3, 8'h00, 1'b0);
        add_entry(8'h61, 8'h45, 8'h67, 8'hff, 8'h00, 8'hff, 8'h00, 1'b0);
        add_entry(8'h69, 8'h89, 8'hab, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
        add_entry(8'h79, 8'hcd, 8'hef, 8'h81, 8'h00, 8'h81, 8'h00, 1'b0);
        add_entry(8'h40, 8'h12, 8'hfe, 8'h55, 8'h80, 8'h80, 8'h80, 1'b0);
        add_entry(8'h48, 8'h34, 8'h10, 8'h11, 8'h00, 8'h00, 8'h44, 1'b0);
        add_entry(8'h50, 8'h00, 8'h01, 8'h66, 8'hff, 8'hff, 8'h84, 1'b0);
        add_entry(8'h58, 8'hff, 8'h80, 8'h77, 8'h01, 8'h01, 8'h00, 1'b0);
        add_entry(8'h60, 8'h3a, 8'h5b, 8'h88, 8'h03, 8'h03, 8'h04, 1'b0);
        add_entry(8'h68, 8'h7c, 8'hd1, 8'h99, 8'h7f, 8'h7f, 8'h00, 1'b0);
        add_entry(8'h78, 8'h0f, 8'hf0, 8'haa, 8'hc3, 8'hc3, 8'h84, 1'b0);
        add_entry(8'h59, 8'h24, 8'h42, 8'he7, 8'h00, 8'he7, 8'h84, 1'b0);
        add_entry(8'h78, 8'h5e, 8'he5, 8'h10, 8'h2c, 8'h2c, 8'h00, 1'b1);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || io_rd !== 1'b0 || io_wr !== 1'b0) begin
            report_error("busy, done, io_rd or io_wr not low after reset");
        end
        check_flags("flags after reset", flags, 8'h00);
        readback_all();

        foreach (table_q[k]) begin
            e    = table_q[k];
            code = e.opcode[RRR_LSB +: 3];
            for (int i = 0; i < 8; i++) begin
                model[i] = data_t'($urandom);
            end
            model[REG_B] = e.b;
            model[REG_C] = e.c;
            model[code]  = e.pre;
            preload_all();
            exp_addr  = {model[REG_B], model[REG_C]};
            port_byte = e.port_byte;
            run_op(e.opcode, e.poke);
            if (e.opcode[OP_IN_BIT]) begin
                if (wr_windows != 1 || rd_windows != 0) begin
                    report_error($sformatf("OUT gave %0d rd and %0d wr windows",
                                           rd_windows, wr_windows));
                end
                check_data("OUT data", wr_data, e.exp_reg);
                check_addr("OUT address", wr_addr, exp_addr);
            end else begin
                if (rd_windows != 1 || wr_windows != 0) begin
                    report_error($sformatf("IN gave %0d rd and %0d wr windows",
                                           rd_windows, wr_windows));
                end
                check_addr("IN address", rd_addr, exp_addr);
                model[code] = e.exp_reg;
            end
            check_flags("flags after instruction", flags, e.exp_flags);
            readback_all();
            check_flags("flags after readback", flags, e.exp_flags); // OUT keeps F.
        end

        if (error_count == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

endmodule

//--- list.f
z80_op_pkg.sv
z80_bus_pkg.sv
io_sequencer.sv
io_op_decoder.sv
z80_reg_file.sv
io_flag_unit.sv
io_exec_top.sv
io_exec_assert.sv
tb_io_exec.sv

//--- Bender.yml
package:
  name: z80_io_exec

sources:
  - z80_op_pkg.sv
  - z80_bus_pkg.sv
  - io_sequencer.sv
  - io_op_decoder.sv
  - z80_reg_file.sv
  - io_flag_unit.sv
  - io_exec_top.sv
  - target: simulation
    files:
      - io_exec_assert.sv
      - tb_io_exec.sv
